/* Bender.yml */
package:
  name: bus_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/bus_pkg.sv
      - hw/bus_if.sv
      - hw/host_master.sv
      - hw/bus_arbiter.sv
      - hw/mem_slave.sv
      - hw/status_slave.sv
      - hw/led_pager.sv
      - hw/bus_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/bus_top_tb.sv

/* build.f */
+incdir+include
hw/bus_pkg.sv
hw/bus_if.sv
hw/host_master.sv
hw/bus_arbiter.sv
hw/mem_slave.sv
hw/status_slave.sv
hw/led_pager.sv
hw/bus_top.sv
test/tb_clock.sv
test/bus_top_tb.sv

/* hw/bus_arbiter.sv */
`timescale 1ns/1ns
`include "bus_params.svh"

module bus_arbiter import bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    bus_if.slave  m_bus [`BUS_MASTERS],
    bus_if.master mem_bus,
    bus_if.master stat_bus,
    output cnt_t  grant_cnt [`BUS_MASTERS],
    output cnt_t  err_cnt
);

    localparam int IDX_W = (`BUS_MASTERS > 1) ? $clog2(`BUS_MASTERS) : 1;
    localparam int REG_W = `REGION_HI - `REGION_LO + 1;
    localparam logic [REG_W-1:0] REG_MEM  = `REGION_MEM;
    localparam logic [REG_W-1:0] REG_STAT = `REGION_STAT;

    arb_state_t       state;
    logic [IDX_W-1:0] grant_q;
    logic [IDX_W-1:0] last_q;   // last master served
    logic [IDX_W-1:0] sel;
    logic             sel_valid;
    logic [REG_W-1:0] sel_region;
    logic [REG_W-1:0] region_q;

    logic [`BUS_MASTERS-1:0] m_req;
    logic                    m_we    [`BUS_MASTERS];
    addr_t                   m_addr  [`BUS_MASTERS];
    data_t                   m_wdata [`BUS_MASTERS];
    strb_t                   m_strb  [`BUS_MASTERS];

    logic  slv_ack;
    logic  ack_out;
    data_t rdata_out;
    resp_t resp_out;

    for (genvar i = 0; i < `BUS_MASTERS; i++) begin : g_mst
        assign m_req[i]       = m_bus[i].req;
        assign m_we[i]        = m_bus[i].we;
        assign m_addr[i]      = m_bus[i].addr;
        assign m_wdata[i]     = m_bus[i].wdata;
        assign m_strb[i]      = m_bus[i].strb;
        assign m_bus[i].ack   = ack_out && (grant_q == IDX_W'(i));  // granted master only
        assign m_bus[i].rdata = rdata_out;
        assign m_bus[i].resp  = resp_out;
    end

    // round robin, search starts after the last served master
    always_comb begin
        int unsigned cand;
        sel       = last_q;
        sel_valid = 1'b0;
        for (int k = 1; k <= `BUS_MASTERS; k++) begin
            cand = (int'(last_q) + k) % `BUS_MASTERS;
            if (!sel_valid && m_req[cand]) begin
                sel       = cand[IDX_W-1:0];
                sel_valid = 1'b1;
            end
        end
    end

    assign sel_region = m_addr[sel][`REGION_HI:`REGION_LO];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ARB_IDLE;
            grant_q  <= IDX_W'(`BUS_MASTERS - 1);
            last_q   <= IDX_W'(`BUS_MASTERS - 1);  // master 0 wins first
            region_q <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (sel_valid) begin
                        grant_q  <= sel;
                        region_q <= sel_region;
                        state    <= (sel_region == REG_MEM || sel_region == REG_STAT) ?
                                    ARB_BUSY : ARB_ERR;
                    end
                end
                ARB_BUSY: if (slv_ack) state <= ARB_IDLE;
                default:  state <= ARB_IDLE;  // err acks in one cycle
            endcase
            if (ack_out)
                last_q <= grant_q;
        end
    end

    assign mem_bus.req   = (state == ARB_BUSY) && (region_q == REG_MEM);
    assign mem_bus.we    = m_we[grant_q];
    assign mem_bus.addr  = m_addr[grant_q];
    assign mem_bus.wdata = m_wdata[grant_q];
    assign mem_bus.strb  = m_strb[grant_q];

    assign stat_bus.req   = (state == ARB_BUSY) && (region_q == REG_STAT);
    assign stat_bus.we    = m_we[grant_q];
    assign stat_bus.addr  = m_addr[grant_q];
    assign stat_bus.wdata = m_wdata[grant_q];
    assign stat_bus.strb  = m_strb[grant_q];

    assign slv_ack = (region_q == REG_MEM) ? mem_bus.ack : stat_bus.ack;
    assign ack_out = ((state == ARB_BUSY) && slv_ack) || (state == ARB_ERR);

    always_comb begin
        if (state == ARB_ERR) begin
            rdata_out = '0;
            resp_out  = RESP_DECERR;
        end else if (region_q == REG_MEM) begin
            rdata_out = mem_bus.rdata;
            resp_out  = mem_bus.resp;
        end else begin
            rdata_out = stat_bus.rdata;
            resp_out  = stat_bus.resp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BUS_MASTERS; i++)
                grant_cnt[i] <= '0;
            err_cnt <= '0;
        end else if (ack_out) begin
            grant_cnt[grant_q] <= grant_cnt[grant_q] + 1'b1;  // wraps
            if (state == ARB_ERR)
                err_cnt <= err_cnt + 1'b1;
        end
    end

endmodule

/* hw/bus_if.sv */
`timescale 1ns/1ns
`include "bus_params.svh"

// held request, single-cycle ack carrying rdata and resp
interface bus_if;
    logic                   req;
    logic                   we;
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] wdata;
    logic [`BUS_STRB_W-1:0] strb;
    logic                   ack;
    logic [`BUS_DATA_W-1:0] rdata;
    logic [1:0]             resp;

    modport master (
        output req, we, addr, wdata, strb,
        input  ack, rdata, resp
    );

    modport slave (
        input  req, we, addr, wdata, strb,
        output ack, rdata, resp
    );

endinterface

/* hw/bus_pkg.sv */
`include "bus_params.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_DATA_W-1:0] data_t;
    typedef logic [`BUS_STRB_W-1:0] strb_t;

    // response codes as on axi
    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    typedef logic [`CNT_W-1:0] cnt_t;

    typedef logic [1:0] page_t;  // led pager page index

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,  // waiting on slave ack
        ARB_ERR    // unmapped region, reply decerr
    } arb_state_t;

endpackage

/* hw/bus_top.sv */
`timescale 1ns/1ns
`include "bus_params.svh"

module bus_top import bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       a_cmd_valid,
    input  logic       a_cmd_write,
    input  addr_t      a_cmd_addr,
    input  data_t      a_cmd_wdata,
    input  strb_t      a_cmd_strb,
    output logic       a_rsp_valid,
    output data_t      a_rsp_rdata,
    output resp_t      a_rsp_resp,
    input  logic       b_cmd_valid,
    input  logic       b_cmd_write,
    input  addr_t      b_cmd_addr,
    input  data_t      b_cmd_wdata,
    input  strb_t      b_cmd_strb,
    output logic       b_rsp_valid,
    output data_t      b_rsp_rdata,
    output resp_t      b_rsp_resp,
    input  logic [3:0] btn,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    bus_if m_bus [`BUS_MASTERS] ();
    bus_if mem_bus ();
    bus_if stat_bus ();

    cnt_t       grant_cnt [`BUS_MASTERS];
    cnt_t       err_cnt;
    logic [7:0] user_led;

    host_master u_host_a (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (a_cmd_valid),
        .cmd_write (a_cmd_write),
        .cmd_addr  (a_cmd_addr),
        .cmd_wdata (a_cmd_wdata),
        .cmd_strb  (a_cmd_strb),
        .rsp_valid (a_rsp_valid),
        .rsp_rdata (a_rsp_rdata),
        .rsp_resp  (a_rsp_resp),
        .bus       (m_bus[0])
    );

    host_master u_host_b (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (b_cmd_valid),
        .cmd_write (b_cmd_write),
        .cmd_addr  (b_cmd_addr),
        .cmd_wdata (b_cmd_wdata),
        .cmd_strb  (b_cmd_strb),
        .rsp_valid (b_rsp_valid),
        .rsp_rdata (b_rsp_rdata),
        .rsp_resp  (b_rsp_resp),
        .bus       (m_bus[1])
    );

    bus_arbiter u_bus_arbiter (
        .clk       (clk),
        .reset     (reset),
        .m_bus     (m_bus),
        .mem_bus   (mem_bus),
        .stat_bus  (stat_bus),
        .grant_cnt (grant_cnt),
        .err_cnt   (err_cnt)
    );

    mem_slave u_mem_slave (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus)
    );

    status_slave u_status_slave (
        .clk       (clk),
        .reset     (reset),
        .bus       (stat_bus),
        .grant_cnt (grant_cnt),
        .err_cnt   (err_cnt),
        .user_led  (user_led)
    );

    led_pager u_led_pager (
        .clk       (clk),
        .reset     (reset),
        .btn       (btn),
        .grant_cnt (grant_cnt),
        .err_cnt   (err_cnt),
        .user_led  (user_led),
        .led8      (led8),
        .led4      (led4)
    );

endmodule

/* hw/host_master.sv */
`timescale 1ns/1ns

module host_master import bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_valid,
    input  logic  cmd_write,
    input  addr_t cmd_addr,
    input  data_t cmd_wdata,
    input  strb_t cmd_strb,
    output logic  rsp_valid,
    output data_t rsp_rdata,
    output resp_t rsp_resp,
    bus_if.master bus
);

    logic  req_q;
    logic  we_q;
    addr_t addr_q;
    data_t wdata_q;
    strb_t strb_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q     <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_q && bus.ack;
            if (req_q && bus.ack)
                req_q <= 1'b0;
            else if (cmd_valid && !req_q)  // strobes while busy are dropped
                req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && !req_q) begin
            we_q    <= cmd_write;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
            strb_q  <= cmd_strb;
        end
        if (req_q && bus.ack) begin
            rsp_rdata <= bus.rdata;
            rsp_resp  <= bus.resp;
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.strb  = strb_q;

endmodule

/* hw/led_pager.sv */
`timescale 1ns/1ns
`include "bus_params.svh"

module led_pager import bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] btn,
    input  cnt_t       grant_cnt [`BUS_MASTERS],
    input  cnt_t       err_cnt,
    input  logic [7:0] user_led,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    logic [1:0] btn_q;
    logic [1:0] btn_prev;
    logic       step_up;
    logic       step_down;
    page_t      page;
    logic [7:0] page_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            btn_q    <= '0;
            btn_prev <= '0;
        end else begin
            btn_q    <= btn[1:0];  // only up and down are wired
            btn_prev <= btn_q;
        end
    end

    assign step_up   = btn_q[0] && !btn_prev[0];
    assign step_down = btn_q[1] && !btn_prev[1];

    always_comb begin
        case (page)
            2'd0:    page_val = grant_cnt[0];
            2'd1:    page_val = grant_cnt[1];
            2'd2:    page_val = err_cnt;
            default: page_val = user_led;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            page <= '0;
            led8 <= '0;
            led4 <= 4'b0001;
        end else begin
            if (step_up && !step_down)
                page <= page + 1'b1;  // wraps 3 -> 0
            else if (step_down && !step_up)
                page <= page - 1'b1;
            led8 <= page_val;
            led4 <= 4'b0001 << page;
        end
    end

endmodule

/* hw/mem_slave.sv */
`timescale 1ns/1ns
`include "bus_params.svh"

module mem_slave import bus_pkg::*; (
    input  logic clk,
    input  logic reset,
    bus_if.slave bus
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    data_t            mem [`MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ack_q;
    data_t            rdata_q;

    // word index, higher offset bits alias
    assign idx    = bus.addr[IDX_W+1:2];
    assign access = bus.req && !ack_q;  // first cycle of a request

    always_ff @(posedge clk) begin
        if (reset)
            ack_q <= 1'b0;
        else
            ack_q <= access;
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < `BUS_STRB_W; b++) begin
                    if (bus.strb[b])
                        mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;
    assign bus.resp  = RESP_OKAY;

endmodule

/* hw/status_slave.sv */
`timescale 1ns/1ns
`include "bus_params.svh"

module status_slave import bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    bus_if.slave       bus,
    input  cnt_t       grant_cnt [`BUS_MASTERS],
    input  cnt_t       err_cnt,
    output logic [7:0] user_led
);

    localparam logic [`REGION_LO-1:0] OFS_LED   = 'h0;
    localparam logic [`REGION_LO-1:0] OFS_GRANT = 'h4;
    localparam logic [`REGION_LO-1:0] OFS_ERR   = 'h8;

    logic [`REGION_LO-1:0] offset;
    logic                  access;
    logic                  ack_q;
    data_t                 rd_word;
    data_t                 rdata_q;

    assign offset = bus.addr[`REGION_LO-1:0];
    assign access = bus.req && !ack_q;

    always_comb begin
        rd_word = '0;
        case (offset)
            OFS_LED: rd_word[7:0] = user_led;
            OFS_GRANT: begin
                for (int i = 0; i < `BUS_MASTERS; i++)
                    rd_word[i*`CNT_W +: `CNT_W] = grant_cnt[i];  // master 0 lowest
            end
            OFS_ERR: rd_word[`CNT_W-1:0] = err_cnt;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q    <= 1'b0;
            user_led <= '0;
        end else begin
            ack_q <= access;
            if (access && bus.we && bus.strb[0] && offset == OFS_LED)
                user_led <= bus.wdata[7:0];
        end
    end

    // sampled a cycle ahead of the ack, so counts predate this transaction
    always_ff @(posedge clk) begin
        if (access)
            rdata_q <= rd_word;
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;
    assign bus.resp  = RESP_OKAY;

endmodule

/* include/bus_params.svh */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// bus field widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4

// two peer masters on the shared bus
`define BUS_MASTERS 2

// 256 MB regions selected by addr[29:28]
`define REGION_HI 29
`define REGION_LO 28
`define REGION_MEM 0   // word memory, ddr stand-in
`define REGION_STAT 3  // status registers

`define MEM_WORDS 256

// transaction counter width
`define CNT_W 8

`endif

/* test/bus_top_tb.sv */
`timescale 1ns/1ns

module bus_top_tb import bus_pkg::*; ();

    localparam int RSP_LIMIT = 20;  // cycles per command

    logic       clk;
    logic       reset;
    logic       a_cmd_valid;
    logic       a_cmd_write;
    addr_t      a_cmd_addr;
    data_t      a_cmd_wdata;
    strb_t      a_cmd_strb;
    logic       a_rsp_valid;
    data_t      a_rsp_rdata;
    resp_t      a_rsp_resp;
    logic       b_cmd_valid;
    logic       b_cmd_write;
    addr_t      b_cmd_addr;
    data_t      b_cmd_wdata;
    strb_t      b_cmd_strb;
    logic       b_rsp_valid;
    data_t      b_rsp_rdata;
    resp_t      b_rsp_resp;
    logic [3:0] btn;
    logic [7:0] led8;
    logic [3:0] led4;

    // one command slot per port
    logic  slot_en    [2];
    logic  slot_we    [2];
    addr_t slot_addr  [2];
    data_t slot_wdata [2];
    strb_t slot_strb  [2];
    logic  got_rsp    [2];
    data_t got_rdata  [2];
    resp_t got_resp   [2];

    cnt_t       port_cnt [2];  // completed transactions per port
    cnt_t       err_model;
    logic [7:0] led_model;
    page_t      page_model;

    logic [7:0] v_op   [$];
    logic [7:0] v_port [$];
    addr_t      v_addr [$];
    data_t      v_data [$];
    strb_t      v_strb [$];
    data_t      v_exp  [$];

    int     errors;
    int     tests_failed;
    int     limit;
    int     cycles;
    integer seed;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    bus_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .a_cmd_valid (a_cmd_valid),
        .a_cmd_write (a_cmd_write),
        .a_cmd_addr  (a_cmd_addr),
        .a_cmd_wdata (a_cmd_wdata),
        .a_cmd_strb  (a_cmd_strb),
        .a_rsp_valid (a_rsp_valid),
        .a_rsp_rdata (a_rsp_rdata),
        .a_rsp_resp  (a_rsp_resp),
        .b_cmd_valid (b_cmd_valid),
        .b_cmd_write (b_cmd_write),
        .b_cmd_addr  (b_cmd_addr),
        .b_cmd_wdata (b_cmd_wdata),
        .b_cmd_strb  (b_cmd_strb),
        .b_rsp_valid (b_rsp_valid),
        .b_rsp_rdata (b_rsp_rdata),
        .b_rsp_resp  (b_rsp_resp),
        .btn         (btn),
        .led8        (led8),
        .led4        (led4)
    );

    // regions 1 and 2 are unmapped
    function automatic resp_t expected_resp(input addr_t addr);
        logic [1:0] region;
        region = addr[29:28];
        if (region == 2'd1 || region == 2'd2)
            return RESP_DECERR;
        return RESP_OKAY;
    endfunction

    function automatic logic [7:0] page_value(input page_t pg);
        case (pg)
            2'd0:    return port_cnt[0];
            2'd1:    return port_cnt[1];
            2'd2:    return err_model;
            default: return led_model;
        endcase
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t got);
        if (got !== exp) begin
            $display("FAILED %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t got);
        if (got !== exp) begin
            $display("FAILED %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_cnt(input string name, input cnt_t exp, input cnt_t got);
        if (got !== exp) begin
            $display("FAILED %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_led(input logic [7:0] exp8, input logic [3:0] exp4);
        if (led8 !== exp8) begin
            $display("FAILED led8 exp %h got %h", exp8, led8);
            errors++;
        end
        if (led4 !== exp4) begin
            $display("FAILED led4 exp %h got %h", exp4, led4);
            errors++;
        end
    endtask

    task automatic read_vectors();
        int               fd;
        int               n;
        logic [63:0]      tok;
        logic [7:0]       port_tok;
        addr_t            addr;
        data_t            data;
        strb_t            strb;
        data_t            exp;
        logic [8*120-1:0] rest;
        fd = $fopen("test/bus_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file test/bus_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n == 1 && tok == "#") begin
                    n = $fgets(rest, fd);  // comment line
                end else if (n == 1) begin
                    n = $fscanf(fd, " %s %h %h %h %h", port_tok, addr, data, strb, exp);
                    if (n != 5) begin
                        $display("malformed vector line after op %s", tok[7:0]);
                        errors++;
                    end else begin
                        v_op.push_back(tok[7:0]);
                        v_port.push_back(port_tok);
                        v_addr.push_back(addr);
                        v_data.push_back(data);
                        v_strb.push_back(strb);
                        v_exp.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic clear_slots();
        for (int p = 0; p < 2; p++) begin
            slot_en[p]    = 1'b0;
            slot_we[p]    = 1'b0;
            slot_addr[p]  = '0;
            slot_wdata[p] = '0;
            slot_strb[p]  = '0;
        end
    endtask

    task automatic set_slot(input int p, input logic we, input addr_t addr,
                            input data_t wdata, input strb_t strb);
        slot_en[p]    = 1'b1;
        slot_we[p]    = we;
        slot_addr[p]  = addr;
        slot_wdata[p] = wdata;
        slot_strb[p]  = strb;
    endtask

    // one-cycle strobe on the enabled ports, then wait for their responses
    task automatic issue_cmds();
        int waited;
        got_rsp[0] = 1'b0;
        got_rsp[1] = 1'b0;
        @(posedge clk);
        a_cmd_valid <= slot_en[0];
        a_cmd_write <= slot_we[0];
        a_cmd_addr  <= slot_addr[0];
        a_cmd_wdata <= slot_wdata[0];
        a_cmd_strb  <= slot_strb[0];
        b_cmd_valid <= slot_en[1];
        b_cmd_write <= slot_we[1];
        b_cmd_addr  <= slot_addr[1];
        b_cmd_wdata <= slot_wdata[1];
        b_cmd_strb  <= slot_strb[1];
        @(posedge clk);
        a_cmd_valid <= 1'b0;
        b_cmd_valid <= 1'b0;
        waited = 0;
        while (((slot_en[0] && !got_rsp[0]) || (slot_en[1] && !got_rsp[1]))
               && waited < RSP_LIMIT) begin
            @(negedge clk);
            waited++;
            if (a_rsp_valid) begin
                got_rsp[0]   = 1'b1;
                got_rdata[0] = a_rsp_rdata;
                got_resp[0]  = a_rsp_resp;
            end
            if (b_rsp_valid) begin
                got_rsp[1]   = 1'b1;
                got_rdata[1] = b_rsp_rdata;
                got_resp[1]  = b_rsp_resp;
            end
        end
    endtask

    task automatic check_slot(input int p, input data_t exp_data);
        string pn;
        addr_t addr;
        pn   = (p == 0) ? "a" : "b";
        addr = slot_addr[p];
        if (!got_rsp[p]) begin
            $display("port %s gave no response to the command at address %h", pn, addr);
            errors++;
        end else begin
            check_resp($sformatf("%s_rsp_resp", pn), expected_resp(addr), got_resp[p]);
            if (!slot_we[p]) begin
                // counters read as they stood before this transaction
                if (addr[29:28] == 2'd3 && addr[27:0] == 28'h4) begin
                    check_cnt("grant_cnt[0]", port_cnt[0], got_rdata[p][7:0]);
                    check_cnt("grant_cnt[1]", port_cnt[1], got_rdata[p][15:8]);
                end else if (addr[29:28] == 2'd3 && addr[27:0] == 28'h8) begin
                    check_cnt("err_cnt", err_model, got_rdata[p][7:0]);
                end else begin
                    check_data($sformatf("%s_rsp_rdata", pn), exp_data, got_rdata[p]);
                end
            end else if (addr[29:28] == 2'd3 && addr[27:0] == 28'h0 && slot_strb[p][0]) begin
                led_model = slot_wdata[p][7:0];
            end
            port_cnt[p] = port_cnt[p] + 1'b1;
            if (expected_resp(addr) == RESP_DECERR)
                err_model = err_model + 1'b1;
        end
    endtask

    // random words written, then read back through the same port
    task automatic fill_check(input int p, input addr_t base, input int words);
        data_t fill [$];
        data_t word;
        for (int i = 0; i < words; i++) begin
            word = $random(seed);
            fill.push_back(word);
            clear_slots();
            set_slot(p, 1'b1, base + 4 * i, word, 4'hf);
            issue_cmds();
            check_slot(p, '0);
        end
        for (int i = 0; i < words; i++) begin
            clear_slots();
            set_slot(p, 1'b0, base + 4 * i, '0, '0);
            issue_cmds();
            check_slot(p, fill[i]);
        end
    endtask

    task automatic press_button(input int b);
        @(posedge clk);
        btn[b] <= 1'b1;
        repeat (3) @(posedge clk);
        btn[b] <= 1'b0;
        repeat (3) @(posedge clk);  // edge detect and led registers settle
    endtask

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int   errs_before;
        int   p;
        logic we;
        a_cmd_valid  = 1'b0;
        a_cmd_write  = 1'b0;
        a_cmd_addr   = '0;
        a_cmd_wdata  = '0;
        a_cmd_strb   = '0;
        b_cmd_valid  = 1'b0;
        b_cmd_write  = 1'b0;
        b_cmd_addr   = '0;
        b_cmd_wdata  = '0;
        b_cmd_strb   = '0;
        btn          = '0;
        port_cnt[0]  = '0;
        port_cnt[1]  = '0;
        err_model    = '0;
        led_model    = '0;
        page_model   = '0;
        errors       = 0;
        tests_failed = 0;
        limit        = 0;
        seed         = 32'h6e51_da5c;
        clear_slots();
        read_vectors();
        limit = 40 * v_op.size() + 100;

        @(posedge clk);
        while (reset)
            @(posedge clk);

        for (int i = 0; i < v_op.size(); i++) begin
            errs_before = errors;
            p = (v_port[i] == "b") ? 1 : 0;
            clear_slots();
            case (v_op[i])
                "W", "R": begin
                    set_slot(p, v_op[i] == "W", v_addr[i], v_data[i], v_strb[i]);
                    issue_cmds();
                    check_slot(p, v_exp[i]);
                end
                "P": begin  // b works on the next word
                    we = (v_port[i] == "w");
                    set_slot(0, we, v_addr[i], v_data[i], v_strb[i]);
                    set_slot(1, we, v_addr[i] + 4, v_exp[i], v_strb[i]);
                    issue_cmds();
                    check_slot(0, v_data[i]);
                    check_slot(1, v_exp[i]);
                end
                "F": fill_check(p, v_addr[i], int'(v_data[i]));
                "U": begin
                    press_button(0);
                    page_model = page_model + 1'b1;
                end
                "D": begin
                    press_button(1);
                    page_model = page_model - 1'b1;
                end
                "L": begin
                    @(negedge clk);
                    check_led(page_value(page_model), v_exp[i][3:0]);
                end
                default: begin
                    $display("unknown op %s on vector %0d", v_op[i], i);
                    errors++;
                end
            endcase
            if (errors != errs_before)
                tests_failed++;
            $display("test %0d %s %s %h %s", i, v_op[i], v_port[i], v_addr[i],
                     (errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d failed, %0d check errors", v_op.size(), tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* test/bus_vectors.txt */
# op port addr data strb exp, all fields after port in hex, port a/b or - when unused
# R exp is rdata; P a uses addr/data, b uses addr+4/exp; F data is word count; L exp is led4
W a 00000000 11223344 f 0
W b 00000004 a5a5a5a5 f 0
R b 00000000 0 0 11223344
R a 00000004 0 0 a5a5a5a5
W a 00000000 000000ee 1 0
W b 00000000 99880000 c 0
R a 00000000 0 0 998833ee
F b 00000100 8 f 0
R a 10000010 0 0 00000000
W b 20000000 deadbeef f 0
R b 30000008 0 0 0
P w 00000020 cafe0001 f cafe0002
P r 00000020 cafe0001 0 cafe0002
R a 30000004 0 0 0
W a 30000000 0000005a 1 0
W b 30000000 000000ff 2 0
R b 30000000 0 0 0000005a
L - 0 0 0 1
D - 0 0 0 0
L - 0 0 0 8
U - 0 0 0 0
U - 0 0 0 0
L - 0 0 0 2
U - 0 0 0 0
L - 0 0 0 4
U - 0 0 0 0
U - 0 0 0 0
L - 0 0 0 1

/* test/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
